// ==== hw/imuldiv_msg_pkg.sv ====
// multiply/divide message definitions
// function codes and field widths of the request and response messages

package imuldiv_msg_pkg;

  // ------------------------------------------------------------
  // field widths
  // ------------------------------------------------------------

  // function code field
  localparam int FN_W = 2;

  // each request operand
  localparam int OPERAND_W = 32;

  // response payload, twice an operand
  // multiply -> full product
  // divide   -> remainder in upper half, quotient in lower half
  localparam int RESULT_W = 2 * OPERAND_W;

  // ------------------------------------------------------------
  // function codes
  // ------------------------------------------------------------

  // FN_MUL  signed multiply
  // FN_DIV  signed divide, quotient truncates toward zero
  // FN_DIVU unsigned divide
  // code 3 is unused and never accepted by the unit
  typedef enum logic [FN_W-1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } muldiv_fn_e;

endpackage

// ==== hw/imuldiv_ctrl_pkg.sv ====
// iterative engine control definitions
// state encoding and iteration count shared by multiplier and divider

package imuldiv_ctrl_pkg;

  // engine state
  // idle accepts a request, calc iterates, done holds the response
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } iter_state_e;

  // one calc cycle per operand bit
  localparam int ITER_COUNT = 32;

  // counter runs 0 .. ITER_COUNT-1
  localparam int COUNT_W = 5;

endpackage

// ==== hw/imuldiv_unit_if.sv ====
// engine bus
// request and response signals between the dispatch, one engine and the arbiter

`timescale 1ns/10ps

interface imuldiv_unit_if;

  // ------------------------------------------------------------
  // request side, driven by the top level dispatch
  // ------------------------------------------------------------
  logic                                   req_val;
  imuldiv_msg_pkg::muldiv_fn_e            req_fn;
  logic [imuldiv_msg_pkg::OPERAND_W-1:0]  req_a;
  logic [imuldiv_msg_pkg::OPERAND_W-1:0]  req_b;

  // engine says it can take a request
  logic                                   req_rdy;

  // ------------------------------------------------------------
  // response side
  // ------------------------------------------------------------
  logic                                   resp_val;
  imuldiv_msg_pkg::muldiv_fn_e            resp_fn;
  logic [imuldiv_msg_pkg::RESULT_W-1:0]   resp_result;

  // arbiter hands the bus to this engine
  logic                                   resp_rdy;

  // engine side of the bus
  modport engine (
    input  req_val, req_fn, req_a, req_b,
    output req_rdy,
    output resp_val, resp_fn, resp_result,
    input  resp_rdy
  );

  // arbiter only sees the response half
  modport arbiter (
    input  resp_val, resp_fn, resp_result,
    output resp_rdy
  );

endinterface

// ==== hw/int_mul_iterative.sv ====
// iterative signed multiplier
// 32x32 shift-add on operand magnitudes, sign fixed up at the end

`timescale 1ns/10ps

module int_mul_iterative (
  input  logic           clk,
  input  logic           reset,
  imuldiv_unit_if.engine bus
);

  imuldiv_ctrl_pkg::iter_state_e               state;
  logic [imuldiv_ctrl_pkg::COUNT_W-1:0]        count;

  // datapath registers
  logic [imuldiv_msg_pkg::RESULT_W-1:0]        mcand_reg;
  logic [imuldiv_msg_pkg::OPERAND_W-1:0]       mplier_reg;
  logic [imuldiv_msg_pkg::RESULT_W-1:0]        acc_reg;
  logic                                        neg_reg;

  logic [imuldiv_msg_pkg::OPERAND_W-1:0]       a_mag;
  logic [imuldiv_msg_pkg::OPERAND_W-1:0]       b_mag;
  logic                                        req_go;
  logic                                        resp_go;
  logic                                        last_iter;

  // handshakes
  assign req_go    = bus.req_val && bus.req_rdy;
  assign resp_go   = bus.resp_val && bus.resp_rdy;
  assign last_iter = (count == imuldiv_ctrl_pkg::COUNT_W'(imuldiv_ctrl_pkg::ITER_COUNT - 1));

  // operand magnitudes
  // most negative value maps to 2^31, still correct as unsigned
  assign a_mag = bus.req_a[imuldiv_msg_pkg::OPERAND_W-1] ? (~bus.req_a + 1'b1) : bus.req_a;
  assign b_mag = bus.req_b[imuldiv_msg_pkg::OPERAND_W-1] ? (~bus.req_b + 1'b1) : bus.req_b;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_ctrl_pkg::ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        imuldiv_ctrl_pkg::ST_IDLE: begin
          if (req_go) begin
            state <= imuldiv_ctrl_pkg::ST_CALC;
            count <= '0;
          end
        end
        imuldiv_ctrl_pkg::ST_CALC: begin
          // 32nd iteration lands on done
          if (last_iter) begin
            state <= imuldiv_ctrl_pkg::ST_DONE;
          end
          count <= count + 1'b1;
        end
        imuldiv_ctrl_pkg::ST_DONE: begin
          // hold the product until the arbiter takes it
          if (resp_go) begin
            state <= imuldiv_ctrl_pkg::ST_IDLE;
          end
        end
        default: state <= imuldiv_ctrl_pkg::ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand_reg  <= {{imuldiv_msg_pkg::OPERAND_W{1'b0}}, a_mag};
      mplier_reg <= b_mag;
      acc_reg    <= '0;
      // product is negative when exactly one operand is
      neg_reg    <= bus.req_a[imuldiv_msg_pkg::OPERAND_W-1] ^
                    bus.req_b[imuldiv_msg_pkg::OPERAND_W-1];
    end else if (state == imuldiv_ctrl_pkg::ST_CALC) begin
      // add when the low multiplier bit is set
      if (mplier_reg[0]) begin
        acc_reg <= acc_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  // outputs
  assign bus.req_rdy     = (state == imuldiv_ctrl_pkg::ST_IDLE);
  assign bus.resp_val    = (state == imuldiv_ctrl_pkg::ST_DONE);
  assign bus.resp_fn     = imuldiv_msg_pkg::FN_MUL;
  assign bus.resp_result = neg_reg ? (~acc_reg + 1'b1) : acc_reg;

endmodule

// ==== hw/int_div_iterative.sv ====
// iterative restoring divider
// signed and unsigned 32-bit divide, returns remainder and quotient together

`timescale 1ns/10ps

module int_div_iterative (
  input  logic           clk,
  input  logic           reset,
  imuldiv_unit_if.engine bus
);

  imuldiv_ctrl_pkg::iter_state_e               state;
  logic [imuldiv_ctrl_pkg::COUNT_W-1:0]        count;

  // captured request info
  imuldiv_msg_pkg::muldiv_fn_e                 fn_reg;
  logic                                        sign_a_reg;
  logic                                        sign_b_reg;

  // 65-bit working registers
  // rq_reg holds partial remainder above, quotient bits shifting in below
  logic [imuldiv_msg_pkg::RESULT_W:0]          rq_reg;
  logic [imuldiv_msg_pkg::RESULT_W:0]          dvsr_reg;

  logic                                        req_signed;
  logic                                        is_signed;
  logic [imuldiv_msg_pkg::OPERAND_W-1:0]       a_in;
  logic [imuldiv_msg_pkg::OPERAND_W-1:0]       b_in;
  logic [imuldiv_msg_pkg::RESULT_W:0]          shift_out;
  logic [imuldiv_msg_pkg::RESULT_W:0]          diff_out;
  logic [imuldiv_msg_pkg::RESULT_W:0]          rq_next;
  logic [imuldiv_msg_pkg::OPERAND_W-1:0]       quot_mag;
  logic [imuldiv_msg_pkg::OPERAND_W-1:0]       rem_mag;
  logic                                        quot_neg;
  logic                                        rem_neg;
  logic                                        req_go;
  logic                                        resp_go;
  logic                                        last_iter;

  assign req_go    = bus.req_val && bus.req_rdy;
  assign resp_go   = bus.resp_val && bus.resp_rdy;
  assign last_iter = (count == imuldiv_ctrl_pkg::COUNT_W'(imuldiv_ctrl_pkg::ITER_COUNT - 1));

  // ------------------------------------------------------------
  // operand preparation
  // ------------------------------------------------------------

  // only FN_DIV treats operands as two's complement
  assign req_signed = (bus.req_fn == imuldiv_msg_pkg::FN_DIV);

  // magnitudes in signed mode, raw bits otherwise
  assign a_in = (req_signed && bus.req_a[imuldiv_msg_pkg::OPERAND_W-1]) ?
                (~bus.req_a + 1'b1) : bus.req_a;
  assign b_in = (req_signed && bus.req_b[imuldiv_msg_pkg::OPERAND_W-1]) ?
                (~bus.req_b + 1'b1) : bus.req_b;

  // ------------------------------------------------------------
  // one restoring step
  // ------------------------------------------------------------

  assign shift_out = rq_reg << 1;
  assign diff_out  = shift_out - dvsr_reg;

  // negative difference -> restore and shift in 0
  // otherwise keep the difference and shift in 1
  assign rq_next = diff_out[imuldiv_msg_pkg::RESULT_W] ?
                   {shift_out[imuldiv_msg_pkg::RESULT_W:1], 1'b0} :
                   {diff_out[imuldiv_msg_pkg::RESULT_W:1], 1'b1};

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_ctrl_pkg::ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        imuldiv_ctrl_pkg::ST_IDLE: begin
          if (req_go) begin
            state <= imuldiv_ctrl_pkg::ST_CALC;
            count <= '0;
          end
        end
        imuldiv_ctrl_pkg::ST_CALC: begin
          if (last_iter) begin
            state <= imuldiv_ctrl_pkg::ST_DONE;
          end
          count <= count + 1'b1;
        end
        imuldiv_ctrl_pkg::ST_DONE: begin
          if (resp_go) begin
            state <= imuldiv_ctrl_pkg::ST_IDLE;
          end
        end
        default: state <= imuldiv_ctrl_pkg::ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // datapath registers
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      fn_reg     <= bus.req_fn;
      sign_a_reg <= bus.req_a[imuldiv_msg_pkg::OPERAND_W-1];
      sign_b_reg <= bus.req_b[imuldiv_msg_pkg::OPERAND_W-1];
      // dividend low, divisor lined up with the remainder half
      rq_reg     <= {{(imuldiv_msg_pkg::OPERAND_W+1){1'b0}}, a_in};
      dvsr_reg   <= {1'b0, b_in, {imuldiv_msg_pkg::OPERAND_W{1'b0}}};
    end else if (state == imuldiv_ctrl_pkg::ST_CALC) begin
      rq_reg <= rq_next;
    end
  end

  // ------------------------------------------------------------
  // sign fix-up and response
  // ------------------------------------------------------------

  assign is_signed = (fn_reg == imuldiv_msg_pkg::FN_DIV);
  assign quot_mag  = rq_reg[imuldiv_msg_pkg::OPERAND_W-1:0];
  assign rem_mag   = rq_reg[imuldiv_msg_pkg::RESULT_W-1:imuldiv_msg_pkg::OPERAND_W];

  // quotient truncates toward zero, remainder follows the dividend
  assign quot_neg = is_signed && (sign_a_reg ^ sign_b_reg);
  assign rem_neg  = is_signed && sign_a_reg;

  assign bus.req_rdy     = (state == imuldiv_ctrl_pkg::ST_IDLE);
  assign bus.resp_val    = (state == imuldiv_ctrl_pkg::ST_DONE);
  assign bus.resp_fn     = fn_reg;
  assign bus.resp_result = {rem_neg ? (~rem_mag + 1'b1) : rem_mag,
                            quot_neg ? (~quot_mag + 1'b1) : quot_mag};

endmodule

// ==== hw/resp_arbiter.sv ====
// response arbiter
// round-robin grant of the shared response bus between the two engines

`timescale 1ns/10ps

module resp_arbiter (
  input  logic                                  clk,
  input  logic                                  reset,
  imuldiv_unit_if.arbiter                       mul,
  imuldiv_unit_if.arbiter                       div,
  output logic                                  resp_val,
  input  logic                                  resp_rdy,
  output imuldiv_msg_pkg::muldiv_fn_e           resp_fn,
  output logic [imuldiv_msg_pkg::RESULT_W-1:0]  resp_result
);

  // priority pointer, 0 favours the multiplier and 1 the divider
  logic prio_div;
  logic both_val;
  logic grant_mul;
  logic grant_div;
  logic resp_go;

  assign both_val = mul.resp_val && div.resp_val;

  // a lone requester wins outright, a tie goes to the pointer
  assign grant_mul = mul.resp_val && (!div.resp_val || !prio_div);
  assign grant_div = div.resp_val && (!mul.resp_val || prio_div);

  // output mux, no added cycle
  assign resp_val    = grant_mul || grant_div;
  assign resp_fn     = grant_div ? div.resp_fn : mul.resp_fn;
  assign resp_result = grant_div ? div.resp_result : mul.resp_result;

  // only the granted engine sees the downstream ready
  assign mul.resp_rdy = resp_rdy && grant_mul;
  assign div.resp_rdy = resp_rdy && grant_div;

  assign resp_go = resp_val && resp_rdy;

  // ------------------------------------------------------------
  // pointer update
  // ------------------------------------------------------------

  // after a contended transfer the loser gets priority next time
  // an uncontended transfer leaves the pointer alone
  always_ff @(posedge clk) begin
    if (reset) begin
      prio_div <= 1'b0;
    end else if (resp_go && both_val) begin
      prio_div <= grant_mul;
    end
  end

endmodule

// ==== hw/imuldiv_top.sv ====
// iterative multiply/divide unit
// dispatches requests by function code to two engines sharing one response bus

`timescale 1ns/10ps

module imuldiv_top (
  input  logic                                   clk,
  input  logic                                   reset,

  // request port
  input  logic                                   req_val,
  output logic                                   req_rdy,
  input  logic [imuldiv_msg_pkg::FN_W-1:0]       req_fn,
  input  logic [imuldiv_msg_pkg::OPERAND_W-1:0]  req_a,
  input  logic [imuldiv_msg_pkg::OPERAND_W-1:0]  req_b,

  // response port
  output logic                                   resp_val,
  input  logic                                   resp_rdy,
  output logic [imuldiv_msg_pkg::FN_W-1:0]       resp_fn,
  output logic [imuldiv_msg_pkg::RESULT_W-1:0]   resp_result
);

  imuldiv_unit_if mul_bus ();
  imuldiv_unit_if div_bus ();

  imuldiv_msg_pkg::muldiv_fn_e fn;
  logic                        sel_mul;
  logic                        sel_div;

  // ------------------------------------------------------------
  // dispatch
  // ------------------------------------------------------------

  assign fn = imuldiv_msg_pkg::muldiv_fn_e'(req_fn);

  // code 3 selects neither engine, so it is never accepted
  always_comb begin
    sel_mul = 1'b0;
    sel_div = 1'b0;
    case (fn)
      imuldiv_msg_pkg::FN_MUL:  sel_mul = 1'b1;
      imuldiv_msg_pkg::FN_DIV:  sel_div = 1'b1;
      imuldiv_msg_pkg::FN_DIVU: sel_div = 1'b1;
      default: ;
    endcase
  end

  // request payload fans out to both, only val is steered
  assign mul_bus.req_val = req_val && sel_mul;
  assign mul_bus.req_fn  = fn;
  assign mul_bus.req_a   = req_a;
  assign mul_bus.req_b   = req_b;

  assign div_bus.req_val = req_val && sel_div;
  assign div_bus.req_fn  = fn;
  assign div_bus.req_a   = req_a;
  assign div_bus.req_b   = req_b;

  // ready comes back from the selected engine
  assign req_rdy = (sel_mul && mul_bus.req_rdy) || (sel_div && div_bus.req_rdy);

  // ------------------------------------------------------------
  // engines and response arbiter
  // ------------------------------------------------------------

  int_mul_iterative mul0 (
    .clk   (clk),
    .reset (reset),
    .bus   (mul_bus)
  );

  int_div_iterative div0 (
    .clk   (clk),
    .reset (reset),
    .bus   (div_bus)
  );

  resp_arbiter arb0 (
    .clk         (clk),
    .reset       (reset),
    .mul         (mul_bus),
    .div         (div_bus),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_fn     (resp_fn),
    .resp_result (resp_result)
  );

endmodule

// ==== verif/imuldiv_tb.sv ====
// multiply/divide unit testbench
// random and edge-case requests checked against a reference model and protocol assertions

`timescale 1ns/10ps

module imuldiv_tb;

  logic        clk;
  logic        reset;
  logic        req_val;
  logic        req_rdy;
  logic [1:0]  req_fn;
  logic [31:0] req_a;
  logic [31:0] req_b;
  logic        resp_val;
  logic        resp_rdy;
  logic [1:0]  resp_fn;
  logic [63:0] resp_result;

  // expected {fn, result} per engine queue, each matched in order
  logic [65:0] exp_mul_q[$];
  logic [65:0] exp_div_q[$];

  integer seed;
  int     wait_limit = 200;
  int     cycle;
  int     acc_cycle;
  int     err_count;
  int     check_count;
  int     test_err0;
  int     tests_run;
  int     tests_failed;
  string  test_name;
  logic   hold_window;
  logic   probe_busy;

  imuldiv_top dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_fn     (resp_fn),
    .resp_result (resp_result)
  );

  // 4 ns period
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic void log_error(input string msg);
    $display("%s", msg);
    err_count++;
  endfunction

  function automatic void report_timeout(input string what);
    log_error($sformatf("%s: timeout, %s", test_name, what));
  endfunction

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  function automatic logic [65:0] expected_result(input logic [1:0] fn,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    longint      sa;
    longint      sb;
    longint      q;
    longint      r;
    logic [63:0] res;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    if (fn == imuldiv_msg_pkg::FN_MUL) begin
      // full 64-bit signed product
      res = sa * sb;
    end else if (fn == imuldiv_msg_pkg::FN_DIV) begin
      // truncating divide where the remainder keeps the dividend's sign
      q   = sa / sb;
      r   = sa % sb;
      res = {r[31:0], q[31:0]};
    end else begin
      res = {a % b, a / b};
    end
    return {fn, res};
  endfunction

  function automatic logic [31:0] nonzero_rand();
    logic [31:0] v;
    v = $random(seed);
    if (v == 32'd0) begin
      v = 32'd1;
    end
    return v;
  endfunction

  // ------------------------------------------------------------
  // response scoreboard
  // ------------------------------------------------------------

  always @(posedge clk) begin
    logic [65:0] want;
    logic [65:0] got;
    logic        have;
    if (!reset && resp_val && resp_rdy) begin
      got  = {resp_fn, resp_result};
      want = '0;
      // resp_fn picks the engine queue
      if (resp_fn == imuldiv_msg_pkg::FN_MUL) begin
        have = (exp_mul_q.size() != 0);
        if (have) begin
          want = exp_mul_q.pop_front();
        end
      end else begin
        have = (exp_div_q.size() != 0);
        if (have) begin
          want = exp_div_q.pop_front();
        end
      end
      if (!have) begin
        log_error($sformatf("%s: response arrived with no request outstanding", test_name));
      end else begin
        check_count++;
        assert (got == want)
          else log_error($sformatf("FAILED %s: expected %h actual %h", test_name, want, got));
      end
    end
  end

  // ------------------------------------------------------------
  // protocol assertions
  // ------------------------------------------------------------

  // idle and ready in the first cycle out of reset
  assert property (@(posedge clk) $fell(reset) |-> (req_rdy && !resp_val))
    else log_error($sformatf("%s: unit not idle and ready after reset", test_name));

  // a held response must not move while the bus is stalled
  assert property (@(posedge clk) disable iff (reset)
                   (hold_window && !resp_rdy) |=>
                   (resp_val && $stable(resp_fn) && $stable(resp_result)))
    else log_error($sformatf("%s: response dropped or changed while held", test_name));

  // busy divider refuses another divide
  assert property (@(posedge clk) disable iff (reset) probe_busy |-> !req_rdy)
    else log_error($sformatf("%s: req_rdy high for a divide while divider busy", test_name));

  // ------------------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------------------

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = err_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_count == test_err0) begin
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed, %0d errors", test_name, err_count - test_err0);
    end
  endtask

  // raise a request and hold it until the edge where it transfers
  task automatic send(input logic [1:0] fn, input logic [31:0] a, input logic [31:0] b);
    int n;
    n       = 0;
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    // dispatch ready follows req_fn combinationally
    #1;
    while (!req_rdy && n < wait_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!req_rdy) begin
      report_timeout("request never accepted");
      req_val = 1'b0;
    end else begin
      // transfer on the next edge
      @(posedge clk);
      #1;
      acc_cycle = cycle;
      req_val   = 1'b0;
      if (fn == imuldiv_msg_pkg::FN_MUL) begin
        exp_mul_q.push_back(expected_result(fn, a, b));
      end else begin
        exp_div_q.push_back(expected_result(fn, a, b));
      end
    end
  endtask

  task automatic wait_drain(output int n);
    n = 0;
    while ((exp_mul_q.size() != 0 || exp_div_q.size() != 0) && n < wait_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (exp_mul_q.size() != 0 || exp_div_q.size() != 0) begin
      report_timeout("outstanding responses never arrived");
      exp_mul_q.delete();
      exp_div_q.delete();
    end
  endtask

  // one uncontended request with an optional check of the 32-cycle latency
  task automatic run_op(input logic [1:0] fn, input logic [31:0] a, input logic [31:0] b,
                        input logic timed);
    int n;
    send(fn, a, b);
    if (timed) begin
      n = 0;
      while (!resp_val && n < wait_limit) begin
        @(posedge clk);
        #1;
        n++;
      end
      if (!resp_val) begin
        report_timeout("resp_val never rose");
      end else begin
        check_count++;
        assert (n == 32)
          else log_error($sformatf("FAILED %s: expected latency 32 actual %0d", test_name, n));
      end
    end
    wait_drain(n);
  endtask

  // issue a divide and a multiply under back-pressure and release both
  task automatic contend_round(output logic [1:0] first_fn);
    int div_acc;
    int n;
    resp_rdy = 1'b0;
    send(imuldiv_msg_pkg::FN_DIV, $random(seed), nonzero_rand());
    div_acc = acc_cycle;
    send(imuldiv_msg_pkg::FN_MUL, $random(seed), $random(seed));
    // multiply goes straight in behind the divide
    check_count++;
    assert (acc_cycle == div_acc + 1)
      else log_error($sformatf("FAILED %s: expected accept cycle %0d actual %0d",
                               test_name, div_acc + 1, acc_cycle));
    probe_busy = 1'b1;
    req_fn     = imuldiv_msg_pkg::FN_DIV;
    n = 0;
    while (n < 3) begin
      @(posedge clk);
      #1;
      n++;
    end
    probe_busy = 1'b0;
    req_fn     = imuldiv_msg_pkg::FN_MUL;
    // multiply is done 32 edges after its acceptance and the divide one edge earlier
    n = 0;
    while (cycle < acc_cycle + 32 && n < wait_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (cycle < acc_cycle + 32) begin
      report_timeout("engines never finished");
    end
    hold_window = 1'b1;
    n = 0;
    while (n < 4) begin
      @(posedge clk);
      #1;
      n++;
    end
    first_fn    = resp_fn;
    hold_window = 1'b0;
    resp_rdy    = 1'b1;
    wait_drain(n);
    check_count++;
    assert (n == 2)
      else log_error($sformatf("FAILED %s: expected drain cycles 2 actual %0d", test_name, n));
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial begin
    logic [1:0]  prev_fn;
    logic [1:0]  fn;
    logic [1:0]  want_fn;
    logic [31:0] a;
    logic [31:0] b;
    int          i;
    int          n;
    clk          = 1'b0;
    reset        = 1'b1;
    req_val      = 1'b0;
    req_fn       = imuldiv_msg_pkg::FN_MUL;
    req_a        = '0;
    req_b        = '0;
    resp_rdy     = 1'b1;
    hold_window  = 1'b0;
    probe_busy   = 1'b0;
    seed         = 54;
    cycle        = 0;
    err_count    = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;

    begin_test("reset");
    n = 0;
    while (n < 2) begin
      @(posedge clk);
      n++;
    end
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;
    end_test();

    begin_test("unsigned divide");
    for (i = 0; i < 20; i++) begin
      a = $random(seed);
      b = nonzero_rand();
      // odd pairs get a small dividend so the divisor is larger
      if (i % 2 == 1) begin
        a = a >> 12;
      end
      if (i % 4 == 2) begin
        b = {24'd0, b[7:0]} | 32'd1;
      end
      run_op(imuldiv_msg_pkg::FN_DIVU, a, b, 1'b0);
    end
    end_test();

    begin_test("signed divide");
    // +-7 by +-2
    for (i = 0; i < 4; i++) begin
      a = (i % 2 == 0) ? 32'd7 : -32'd7;
      b = (i < 2) ? 32'd2 : -32'd2;
      run_op(imuldiv_msg_pkg::FN_DIV, a, b, 1'b1);
    end
    for (i = 0; i < 10; i++) begin
      run_op(imuldiv_msg_pkg::FN_DIV, $random(seed), nonzero_rand(), 1'b1);
    end
    end_test();

    begin_test("signed multiply");
    run_op(imuldiv_msg_pkg::FN_MUL, 32'd0, $random(seed), 1'b0);
    run_op(imuldiv_msg_pkg::FN_MUL, -32'd1, -32'd1, 1'b0);
    run_op(imuldiv_msg_pkg::FN_MUL, 32'h8000_0000, 32'h8000_0000, 1'b0);
    run_op(imuldiv_msg_pkg::FN_MUL, 32'h8000_0000, -32'd1, 1'b0);
    run_op(imuldiv_msg_pkg::FN_MUL, 32'h8000_0000, 32'd1, 1'b0);
    run_op(imuldiv_msg_pkg::FN_MUL, -32'd1, $random(seed), 1'b0);
    for (i = 0; i < 10; i++) begin
      run_op(imuldiv_msg_pkg::FN_MUL, $random(seed), $random(seed), 1'b0);
    end
    end_test();

    begin_test("concurrency");
    contend_round(prev_fn);
    end_test();

    begin_test("arbitration");
    for (i = 0; i < 4; i++) begin
      contend_round(fn);
      // engine granted first flips every round
      want_fn = (prev_fn == imuldiv_msg_pkg::FN_MUL) ? imuldiv_msg_pkg::FN_DIV :
                                                       imuldiv_msg_pkg::FN_MUL;
      check_count++;
      assert (fn == want_fn)
        else log_error($sformatf("FAILED %s: expected first fn %0d actual %0d",
                                 test_name, want_fn, fn));
      prev_fn = fn;
    end
    end_test();

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
hw/imuldiv_msg_pkg.sv
hw/imuldiv_ctrl_pkg.sv
hw/imuldiv_unit_if.sv
hw/int_mul_iterative.sv
hw/int_div_iterative.sv
hw/resp_arbiter.sv
hw/imuldiv_top.sv
verif/imuldiv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the multiply/divide unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module imuldiv_tb -f compile.f -o imuldiv_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/imuldiv_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides pass or fail
if grep -q "^Finished with no errors$" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
